/* engine_config.svh */
`ifndef ENGINE_CONFIG_SVH
`define ENGINE_CONFIG_SVH

// Lanes per burst and beats per DMA burst
`define BURST_LEN 16
`define SAMPLE_W  16
`define ADDR_W    30  // DMA word address

// APB register byte offsets
`define REG_OP     8'h00
`define REG_CNT    8'h04
`define REG_DADDR  8'h08
`define REG_WADDR  8'h0C
`define REG_RADDR  8'h10
`define REG_CTRL   8'h14
`define REG_STATUS 8'h18

`endif

/* engine_types_pkg.sv */
`include "engine_config.svh"

package engine_types_pkg;

	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// One value per lane, lane 0 in the low word
	typedef sample_t [`BURST_LEN-1:0] lane_vec_t;

	typedef logic [`ADDR_W-1:0] dma_addr_t;

	// Log2 of the burst count, and the burst counters
	typedef logic [2:0] cnt_log2_t;
	typedef logic [7:0] burst_cnt_t;  // Holds up to 2^7 bursts

	typedef enum logic [2:0] {
		OP_CONV  = 3'd1,
		OP_MPOOL = 3'd4,
		OP_APOOL = 3'd5
	} op_t;

	typedef struct packed {
		op_t       op;
		cnt_log2_t count_log2;
		dma_addr_t data_addr;
		dma_addr_t weight_addr;
		dma_addr_t result_addr;
	} op_cfg_t;

endpackage

/* engine_bus_pkg.sv */
package engine_bus_pkg;

	import engine_types_pkg::*;

	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Host to slave
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// Slave to host
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	// Burst request, en held for the whole burst
	typedef struct packed {
		logic      en;
		dma_addr_t addr;
	} dma_cmd_t;

	// Read ports: data delivered; write port: data valid
	typedef struct packed {
		logic    strobe;
		sample_t data;
	} dma_beat_t;

endpackage

/* csb_regs.sv */
`timescale 1ns/1ps
`include "engine_config.svh"

module csb_regs import engine_types_pkg::*, engine_bus_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  apb_req_t apb_req,
	input  logic     busy,
	input  logic     done_pulse,
	output apb_rsp_t apb_rsp,
	output op_cfg_t  cfg,
	output logic     start
);

	op_cfg_t   cfg_q;
	logic      done_q;
	logic      start_q;
	apb_data_t prdata_q;
	logic      pslverr_q;
	apb_data_t rd_data;
	logic      rd_err;
	logic      setup;
	logic      wr_acc;

	assign setup  = apb_req.psel && !apb_req.penable;
	assign wr_acc = apb_req.psel && apb_req.penable && apb_req.pwrite;

	// Register read mux, also flags unmapped offsets
	always_comb begin
		rd_data = '0;
		rd_err  = 1'b0;
		case (apb_req.paddr)
			`REG_OP:     rd_data[2:0] = cfg_q.op;
			`REG_CNT:    rd_data[2:0] = cfg_q.count_log2;
			`REG_DADDR:  rd_data[`ADDR_W-1:0] = cfg_q.data_addr;
			`REG_WADDR:  rd_data[`ADDR_W-1:0] = cfg_q.weight_addr;
			`REG_RADDR:  rd_data[`ADDR_W-1:0] = cfg_q.result_addr;
			`REG_CTRL:   rd_data = '0;  // Start bit reads back as zero
			`REG_STATUS: rd_data[1:0] = {done_q, busy};
			default:     rd_err = 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cfg_q     <= '0;
			done_q    <= 1'b0;
			start_q   <= 1'b0;
			prdata_q  <= '0;
			pslverr_q <= 1'b0;
		end else begin
			// Response captured in setup, presented in access
			prdata_q  <= setup ? rd_data : '0;
			pslverr_q <= setup && rd_err;

			start_q <= wr_acc && (apb_req.paddr == `REG_CTRL) && apb_req.pwdata[0]
				&& !busy && !start_q;

			if (start_q)
				done_q <= 1'b0;
			else if (done_pulse)
				done_q <= 1'b1;  // Sticky until next start

			if (wr_acc) begin
				case (apb_req.paddr)
					`REG_OP:    cfg_q.op <= op_t'(apb_req.pwdata[2:0]);
					`REG_CNT:   cfg_q.count_log2 <= apb_req.pwdata[2:0];
					`REG_DADDR: cfg_q.data_addr <= apb_req.pwdata[`ADDR_W-1:0];
					`REG_WADDR: cfg_q.weight_addr <= apb_req.pwdata[`ADDR_W-1:0];
					`REG_RADDR: cfg_q.result_addr <= apb_req.pwdata[`ADDR_W-1:0];
					default:    ;
				endcase
			end
		end
	end

	assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: pslverr_q};
	assign cfg     = cfg_q;
	assign start   = start_q;

	// Engine must be idle whenever a start reaches it
	assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

/* cmac.sv */
`timescale 1ns/1ps

module cmac import engine_types_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    clear,
	input  logic    step,
	input  sample_t data,
	input  sample_t weight,
	output sample_t result
);

	localparam int SW = $bits(sample_t);

	sample_t               acc;
	logic signed [2*SW-1:0] prod;

	assign prod = data * weight;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else if (clear) begin
			acc <= '0;
		end else if (step) begin
			acc <= sample_t'(acc + prod[SW-1:0]);  // Wraps at 16 bits
		end
	end

	assign result = acc;

	// Engine never clears and steps a lane in one cycle
	assert property (@(posedge clk) disable iff (rst) !(clear && step));

endmodule

/* pool_lane.sv */
`timescale 1ns/1ps

module pool_lane import engine_types_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       clear,
	input  logic       step,
	input  logic       is_max,
	input  logic       shift_en,
	input  logic [2:0] shift_amt,
	input  sample_t    data,
	output sample_t    result
);

	sample_t acc;
	logic    first;  // No sample seen since clear

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc   <= '0;
			first <= 1'b1;
		end else if (clear) begin
			acc   <= '0;
			first <= 1'b1;
		end else if (step) begin
			first <= 1'b0;
			if (is_max) begin
				if (first || data > acc)
					acc <= data;
			end else begin
				acc <= sample_t'(acc + data);
			end
		end else if (shift_en) begin
			acc <= acc >>> shift_amt;  // Sum to average
		end
	end

	assign result = acc;

endmodule

/* burst_deser.sv */
`timescale 1ns/1ps
`include "engine_config.svh"

module burst_deser import engine_types_pkg::*, engine_bus_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  dma_beat_t beat,
	input  logic      consume,
	output lane_vec_t vec,
	output logic      full
);

	localparam int IDX_W = $clog2(`BURST_LEN);

	logic [IDX_W-1:0] idx;  // Lane for the next beat
	lane_vec_t        buf_q;
	logic             full_q;
	logic             last_beat;

	assign last_beat = beat.strobe && (idx == IDX_W'(`BURST_LEN - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx    <= '0;
			full_q <= 1'b0;
		end else begin
			if (beat.strobe)
				idx <= idx + 1'b1;  // Wraps to lane 0 after the last beat
			if (last_beat)
				full_q <= 1'b1;
			else if (consume)
				full_q <= 1'b0;
		end
	end

	// Sample storage
	always_ff @(posedge clk) begin
		if (beat.strobe)
			buf_q[idx] <= beat.data;
	end

	assign vec  = buf_q;
	assign full = full_q;

	// Next burst is only requested after the buffer was drained
	assert property (@(posedge clk) disable iff (rst) beat.strobe |-> !full_q);

endmodule

/* engine.sv */
`timescale 1ns/1ps
`include "engine_config.svh"

module engine import engine_types_pkg::*, engine_bus_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  op_cfg_t   cfg,
	input  logic      start,
	input  dma_beat_t dma_d_beat,
	input  dma_beat_t dma_w_beat,
	input  logic      wr_ready,
	output logic      busy,
	output logic      done_pulse,
	output dma_cmd_t  dma_d_cmd,
	output dma_cmd_t  dma_w_cmd,
	output dma_cmd_t  wr_cmd,
	output dma_beat_t wr_beat
);

	localparam int LANE_W = $clog2(`BURST_LEN);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_STEP,
		S_SHIFT,
		S_WRITE,
		S_FINISH
	} state_t;

	state_t          state;
	state_t          state_nx;
	op_cfg_t         cfg_q;     // Latched at start
	burst_cnt_t      n_bursts;
	burst_cnt_t      req_cnt;   // Bursts requested
	burst_cnt_t      step_cnt;  // Bursts stepped into the lanes
	dma_addr_t       rd_off;
	dma_addr_t       d_addr;
	dma_addr_t       w_addr;
	logic            d_en;
	logic            w_en;
	logic            d_full;
	logic            w_full;
	lane_vec_t       d_vec;
	lane_vec_t       w_vec;
	lane_vec_t       conv_res;
	lane_vec_t       pool_res;
	lane_vec_t       out_vec;
	logic            is_conv;
	logic            issue;
	logic            consume;
	logic            lane_clear;
	logic            cmac_step;
	logic            pool_step;
	logic            shift_en;
	logic [LANE_W:0] wr_idx;    // Lanes handed to the write port
	logic            wr_strobe;
	sample_t         wr_data;

	assign is_conv    = (cfg_q.op == OP_CONV);
	assign n_bursts   = burst_cnt_t'(1) << cfg_q.count_log2;
	assign consume    = (state == S_STEP);
	assign lane_clear = (state == S_IDLE) && start;
	assign cmac_step  = consume && is_conv;
	assign pool_step  = consume && !is_conv;
	assign shift_en   = (state == S_SHIFT);
	assign out_vec    = is_conv ? conv_res : pool_res;

	// Next burst goes out once both buffers are free or drained this cycle
	assign issue = (state == S_FETCH || state == S_STEP) && !d_en && !w_en
		&& (req_cnt != n_bursts) && (!d_full || consume) && (!w_full || consume);

	burst_deser u_d_deser (
		.clk     (clk),
		.rst     (rst),
		.beat    (dma_d_beat),
		.consume (consume),
		.vec     (d_vec),
		.full    (d_full)
	);

	// Weight port only runs for convolution
	burst_deser u_w_deser (
		.clk     (clk),
		.rst     (rst),
		.beat    (dma_w_beat),
		.consume (cmac_step),
		.vec     (w_vec),
		.full    (w_full)
	);

	for (genvar i = 0; i < `BURST_LEN; i++) begin : g_lane
		cmac u_cmac (
			.clk    (clk),
			.rst    (rst),
			.clear  (lane_clear),
			.step   (cmac_step),
			.data   (d_vec[i]),
			.weight (w_vec[i]),
			.result (conv_res[i])
		);

		pool_lane u_pool (
			.clk       (clk),
			.rst       (rst),
			.clear     (lane_clear),
			.step      (pool_step),
			.is_max    (cfg_q.op == OP_MPOOL),
			.shift_en  (shift_en),
			.shift_amt (cfg_q.count_log2),
			.data      (d_vec[i]),
			.result    (pool_res[i])
		);
	end

	always_comb begin
		state_nx = state;
		case (state)
			S_IDLE:   if (start) state_nx = S_FETCH;
			S_FETCH:  if (d_full && (w_full || !is_conv)) state_nx = S_STEP;
			S_STEP: begin
				if (step_cnt != n_bursts - 1'b1)
					state_nx = S_FETCH;
				else if (cfg_q.op == OP_APOOL)
					state_nx = S_SHIFT;  // One cycle to average
				else
					state_nx = S_WRITE;
			end
			S_SHIFT:  state_nx = S_WRITE;
			S_WRITE:  if (wr_idx == (LANE_W + 1)'(`BURST_LEN)) state_nx = S_FINISH;
			S_FINISH: state_nx = S_IDLE;
			default:  state_nx = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= S_IDLE;
			req_cnt   <= '0;
			step_cnt  <= '0;
			d_en      <= 1'b0;
			w_en      <= 1'b0;
			wr_idx    <= '0;
			wr_strobe <= 1'b0;
		end else begin
			state <= state_nx;
			if (lane_clear) begin
				req_cnt  <= '0;
				step_cnt <= '0;
				wr_idx   <= '0;
			end
			if (issue) begin
				d_en    <= 1'b1;
				w_en    <= is_conv;
				req_cnt <= req_cnt + 1'b1;
			end
			// Drop the request once the burst has landed
			if (d_en && d_full)
				d_en <= 1'b0;
			if (w_en && w_full)
				w_en <= 1'b0;
			if (consume)
				step_cnt <= step_cnt + 1'b1;

			wr_strobe <= 1'b0;  // Low beat on back-pressure
			if (state == S_WRITE && wr_ready && wr_idx != (LANE_W + 1)'(`BURST_LEN)) begin
				wr_strobe <= 1'b1;
				wr_idx    <= wr_idx + 1'b1;
			end
		end
	end

	// Config, burst addresses and write data
	always_ff @(posedge clk) begin
		if (lane_clear) begin
			cfg_q  <= cfg;
			rd_off <= '0;
		end
		if (issue) begin
			d_addr <= cfg_q.data_addr + rd_off;
			w_addr <= cfg_q.weight_addr + rd_off;
			rd_off <= rd_off + dma_addr_t'(`BURST_LEN);
		end
		if (state == S_WRITE && wr_ready)
			wr_data <= out_vec[wr_idx[LANE_W-1:0]];  // Lane 0 first
	end

	assign busy       = (state != S_IDLE);
	assign done_pulse = (state == S_FINISH);
	assign dma_d_cmd  = '{en: d_en, addr: d_addr};
	assign dma_w_cmd  = '{en: w_en, addr: w_addr};
	assign wr_cmd     = '{en: (state == S_WRITE), addr: cfg_q.result_addr};
	assign wr_beat    = '{strobe: wr_strobe, data: wr_data};

	// Each write beat answers a ready from the cycle before
	assert property (@(posedge clk) disable iff (rst) wr_beat.strobe |-> $past(wr_ready));

endmodule

/* engine_top.sv */
`timescale 1ns/1ps

module engine_top import engine_types_pkg::*, engine_bus_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  apb_req_t  apb_req,
	input  dma_beat_t dma_d_beat,
	input  dma_beat_t dma_w_beat,
	input  logic      wr_ready,
	output apb_rsp_t  apb_rsp,
	output dma_cmd_t  dma_d_cmd,
	output dma_cmd_t  dma_w_cmd,
	output dma_cmd_t  wr_cmd,
	output dma_beat_t wr_beat,
	output logic      done
);

	op_cfg_t cfg;
	logic    start;
	logic    busy;

	// Control registers, done feeds the sticky status bit
	csb_regs u_csb (
		.clk        (clk),
		.rst        (rst),
		.apb_req    (apb_req),
		.busy       (busy),
		.done_pulse (done),
		.apb_rsp    (apb_rsp),
		.cfg        (cfg),
		.start      (start)
	);

	engine u_engine (
		.clk        (clk),
		.rst        (rst),
		.cfg        (cfg),
		.start      (start),
		.dma_d_beat (dma_d_beat),
		.dma_w_beat (dma_w_beat),
		.wr_ready   (wr_ready),
		.busy       (busy),
		.done_pulse (done),
		.dma_d_cmd  (dma_d_cmd),
		.dma_w_cmd  (dma_w_cmd),
		.wr_cmd     (wr_cmd),
		.wr_beat    (wr_beat)
	);

endmodule

/* tb_engine.sv */
`timescale 1ns/1ps
`include "engine_config.svh"

module tb_engine import engine_types_pkg::*, engine_bus_pkg::*;;

	localparam int TIMEOUT = 5000;  // Cycles

	logic      clk = 1'b0;
	logic      rst;
	apb_req_t  apb_req;
	apb_rsp_t  apb_rsp;
	dma_beat_t rd_beat [2];  // 0 is data, 1 is weights
	dma_cmd_t  rd_cmd [2];
	logic      wr_ready;
	dma_cmd_t  wr_cmd;
	dma_beat_t wr_beat;
	logic      done;

	sample_t      mem [0:1023];    // Shared data and weight memory
	logic [255:0] gap_pat [2];     // Read gaps per port
	logic [255:0] rdy_pat;         // Write back-pressure
	logic [7:0]   cyc = '0;
	int           exp_base [2];    // Expected first burst address
	int           burst_base [2];
	int           burst_cnt [2] = '{0, 0};
	sample_t      wr_cap [64];
	dma_addr_t    wr_addr_cap [64];
	int           wr_cnt = 0;
	int           done_cnt = 0;
	int           errors = 0;
	int           checks = 0;

	engine_top UUT (
		.clk        (clk),
		.rst        (rst),
		.apb_req    (apb_req),
		.dma_d_beat (rd_beat[0]),
		.dma_w_beat (rd_beat[1]),
		.wr_ready   (wr_ready),
		.apb_rsp    (apb_rsp),
		.dma_d_cmd  (rd_cmd[0]),
		.dma_w_cmd  (rd_cmd[1]),
		.wr_cmd     (wr_cmd),
		.wr_beat    (wr_beat),
		.done       (done)
	);

	always #20 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1'b1;

	always @(posedge clk) wr_ready <= rst ? 1'b0 : rdy_pat[cyc];

	// DMA read ports serving 16 beats per request with random gaps
	for (genvar p = 0; p < 2; p++) begin : g_rd_port
		always begin : serve
			dma_addr_t a;
			int        n;
			int        t;
			@(posedge clk);
			if (!rst && rd_cmd[p].en) begin
				a = rd_cmd[p].addr;
				check_equal($sformatf("port %0d burst address", p),
					exp_base[p] + 16 * (burst_cnt[p] - burst_base[p]), int'(a));
				burst_cnt[p] = burst_cnt[p] + 1;
				n = 0;
				t = 0;
				while (n < `BURST_LEN && t < 200) begin
					if (gap_pat[p][cyc]) begin
						rd_beat[p] <= '0;
					end else begin
						rd_beat[p] <= '{strobe: 1'b1, data: mem[10'(int'(a) + n)]};
						n++;
					end
					t++;
					@(posedge clk);
				end
				rd_beat[p] <= '0;
				t = 0;
				while (rd_cmd[p].en && t < 200) begin  // Request drops after the burst
					@(posedge clk);
					t++;
				end
				if (t == 200) begin
					errors++;
					$display("Read port %0d kept its request up after a full burst", p);
				end
			end
		end
	end

	// Write port and done capture
	always @(posedge clk) begin
		if (!rst) begin
			if (done)
				done_cnt <= done_cnt + 1;
			if (wr_beat.strobe) begin
				wr_cap[6'(wr_cnt)]      <= wr_beat.data;
				wr_addr_cap[6'(wr_cnt)] <= wr_cmd.addr;
				wr_cnt                  <= wr_cnt + 1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) wr_beat.strobe |-> $past(wr_ready))
	else begin
		errors++;
		$display("Write beat strobed without wr_ready in the cycle before");
	end

	assert property (@(posedge clk) disable iff (rst) wr_beat.strobe |-> wr_cmd.en)
	else begin
		errors++;
		$display("Write beat strobed while the write command was not enabled");
	end

	assert property (@(posedge clk) apb_rsp.pready)
	else begin
		errors++;
		$display("APB pready was low");
	end

	assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else begin
		errors++;
		$display("Done stayed high for more than one cycle");
	end

	task automatic check_equal(input string name, input int exp, input int act);
		checks++;
		assert (exp == act)
		else begin
			errors++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Setup then access with read data sampled mid access
	task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input apb_data_t wdata);
		apb_data_t rd;
		logic      err;
		apb_access(1'b1, addr, wdata, rd, err);
		check_equal($sformatf("pslverr on write to 0x%02h", addr), 0, int'(err));
	endtask

	task automatic read_reg(input apb_addr_t addr, output apb_data_t rdata);
		logic err;
		apb_access(1'b0, addr, '0, rdata, err);
		check_equal($sformatf("pslverr on read of 0x%02h", addr), 0, int'(err));
	endtask

	// Expected lane value from the memory image
	function automatic sample_t lane_reference(input op_t op, input int cnt_log2,
		input int daddr, input int waddr, input int lane);
		sample_t acc;
		sample_t d;
		sample_t w;
		acc = '0;
		for (int k = 0; k < (1 << cnt_log2); k++) begin
			d = mem[10'(daddr + 16 * k + lane)];
			w = mem[10'(waddr + 16 * k + lane)];
			case (op)
				OP_CONV:  acc = sample_t'(int'(acc) + int'(d) * int'(w));
				OP_MPOOL: if (k == 0 || d > acc) acc = d;
				default:  acc = sample_t'(int'(acc) + int'(d));
			endcase
		end
		if (op == OP_APOOL)
			acc = acc >>> cnt_log2;  // Average of the bursts
		return acc;
	endfunction

	task automatic run_operation(input string name, input op_t op, input int cnt_log2,
		input int daddr, input int waddr, input int raddr);
		apb_data_t rd;
		int        wr_base;
		int        done_base;
		int        t;
		sample_t   exp;
		write_reg(`REG_OP, apb_data_t'(op));
		write_reg(`REG_CNT, apb_data_t'(cnt_log2));
		write_reg(`REG_DADDR, apb_data_t'(daddr));
		write_reg(`REG_WADDR, apb_data_t'(waddr));
		write_reg(`REG_RADDR, apb_data_t'(raddr));
		exp_base[0]   = daddr;
		exp_base[1]   = waddr;
		burst_base[0] = burst_cnt[0];
		burst_base[1] = burst_cnt[1];
		wr_base       = wr_cnt;
		done_base     = done_cnt;
		write_reg(`REG_CTRL, 32'd1);
		read_reg(`REG_STATUS, rd);
		check_equal({name, " status after start"}, 1, int'(rd[1:0]));  // Busy, done cleared
		t = 0;
		while (done_cnt == done_base && t < TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (done_cnt == done_base) begin
			errors++;
			$display("%s timed out waiting for done", name);
			return;
		end
		repeat (4) @(posedge clk);  // Room for stray beats or pulses
		check_equal({name, " done pulses"}, 1, done_cnt - done_base);
		check_equal({name, " write beats"}, `BURST_LEN, wr_cnt - wr_base);
		check_equal({name, " data bursts"}, 1 << cnt_log2, burst_cnt[0] - burst_base[0]);
		check_equal({name, " weight bursts"}, (op == OP_CONV) ? (1 << cnt_log2) : 0,
			burst_cnt[1] - burst_base[1]);
		for (int lane = 0; lane < `BURST_LEN; lane++) begin
			exp = lane_reference(op, cnt_log2, daddr, waddr, lane);
			check_equal($sformatf("%s lane %0d", name, lane), int'(exp),
				int'(wr_cap[6'(wr_base + lane)]));
			check_equal($sformatf("%s lane %0d address", name, lane), raddr,
				int'(wr_addr_cap[6'(wr_base + lane)]));
		end
		read_reg(`REG_STATUS, rd);
		check_equal({name, " status after done"}, 2, int'(rd[1:0]));
	endtask

	initial begin : main
		apb_data_t rd;
		apb_data_t val [3];
		logic      err;
		rst        = 1'b1;
		apb_req    = '0;
		rd_beat[0] = '0;
		rd_beat[1] = '0;
		wr_ready   = 1'b0;
		void'($urandom(94774));
		for (int i = 0; i < 1024; i++)
			mem[i] = sample_t'($urandom);
		for (int i = 0; i < 256; i++) begin
			gap_pat[0][i] = ($urandom % 4) == 0;
			gap_pat[1][i] = ($urandom % 4) == 0;
			rdy_pat[i]    = ($urandom % 3) != 0;
		end
		for (int k = 0; k < 8; k++)
			mem[10'(12'h080 + 16 * k)][15] = 1'b1;  // Lane 0 of max pooling all negative

		repeat (2) @(posedge clk);
		rst <= 1'b0;

		read_reg(`REG_STATUS, rd);
		check_equal("status after reset", 0, int'(rd));

		// Register read-back
		for (int i = 0; i < 3; i++)
			val[i] = $urandom & 32'h3FFF_FFFF;
		write_reg(`REG_OP, 32'd5);
		write_reg(`REG_CNT, 32'd3);
		write_reg(`REG_DADDR, val[0]);
		write_reg(`REG_WADDR, val[1]);
		write_reg(`REG_RADDR, val[2]);
		read_reg(`REG_OP, rd);
		check_equal("readback op", 5, int'(rd));
		read_reg(`REG_CNT, rd);
		check_equal("readback count", 3, int'(rd));
		read_reg(`REG_DADDR, rd);
		check_equal("readback data address", int'(val[0]), int'(rd));
		read_reg(`REG_WADDR, rd);
		check_equal("readback weight address", int'(val[1]), int'(rd));
		read_reg(`REG_RADDR, rd);
		check_equal("readback result address", int'(val[2]), int'(rd));
		apb_access(1'b0, 8'h1C, '0, rd, err);
		check_equal("pslverr on unmapped read", 1, int'(err));
		apb_access(1'b1, 8'h20, 32'd1, rd, err);
		check_equal("pslverr on unmapped write", 1, int'(err));
		read_reg(`REG_OP, rd);
		check_equal("op after unmapped write", 5, int'(rd));

		run_operation("convolution", OP_CONV, 2, 12'h000, 12'h040, 12'h300);
		run_operation("max pooling", OP_MPOOL, 3, 12'h080, 12'h000, 12'h310);
		run_operation("average pooling", OP_APOOL, 4, 12'h100, 12'h000, 12'h320);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+.
engine_types_pkg.sv
engine_bus_pkg.sv
csb_regs.sv
cmac.sv
pool_lane.sv
burst_deser.sv
engine.sv
engine_top.sv
tb_engine.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_engine
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = FAIL: see errors above

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
